// File: design/trig_leveltwo.sv
`timescale 1ns/1ps
`default_nettype none

module trig_leveltwo import trig_pkg::*; (
    input  wire                sysclk_i,
    input  wire                runrst_i,
    input  wire                running_i,
    input  wire trig_cfg_t     cfg_i,
    input  wire [N_CHAN-1:0]   trigmask_i,
    input  wire                trigmask_update_i,
    input  wire scan_t         scan_i,
    output trig_word_t         trig_word_o
);

    // mask bit set means channel ignored
    logic [N_CHAN-1:0]    mask_q;
    logic [CNT_BITS-1:0]  hold_cnt_q;
    logic [N_CHAN-1:0]    enabled;
    logic [N_CHAN-1:0]    hits;
    logic                 fire;
    logic                 accept;
    logic [ADDR_BITS-1:0] rel_addr;

    // mask may change mid-run, takes effect on the next scanned address
    always_ff @(posedge sysclk_i) begin
        if (runrst_i) begin
            mask_q <= '1;
        end else if (trigmask_update_i) begin
            mask_q <= trigmask_i;
        end
    end

    assign enabled = ~mask_q;
    assign hits    = scan_i.bits & enabled;

    // level two combine
    always_comb begin
        case (cfg_i.l2_logic)
            // every enabled channel, and at least one must be enabled
            L2_AND:  fire = (enabled != '0) && (hits == enabled);
            L2_OR:   fire = |hits;
            default: fire = 1'b0;
        endcase
    end

    // only scanned entries during a run with rf enabled count
    assign accept = fire && cfg_i.rf_en && scan_i.valid && running_i
                    && (hold_cnt_q == '0);

    // holdoff counts scanned addresses, not cycles
    always_ff @(posedge sysclk_i) begin
        if (runrst_i) begin
            hold_cnt_q <= '0;
        end else if (accept) begin
            hold_cnt_q <= cfg_i.holdoff;
        end else if (scan_i.valid && (hold_cnt_q != '0)) begin
            hold_cnt_q <= hold_cnt_q - 1'b1;
        end
    end

    // address relative to the programmed offset
    assign rel_addr = scan_i.addr - cfg_i.offset;

    always_ff @(posedge sysclk_i) begin
        if (runrst_i) begin
            trig_word_o.valid <= 1'b0;
        end else begin
            trig_word_o.valid <= accept;
        end
        // word is 10, address, 00
        trig_word_o.data <= {2'b10, rel_addr, 2'b00};
    end

endmodule

`default_nettype wire

// File: design/trig_out_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module trig_out_fifo import trig_pkg::*; (
    input  wire                   sysclk_i,
    input  wire                   runrst_i,
    input  wire trig_word_t       trig_word_i,
    input  wire                   trigout_tready_i,
    output logic [WORD_BITS-1:0]  trigout_tdata_o,
    output logic                  trigout_tvalid_o,
    output logic                  overflow_o
);

    logic [WORD_BITS-1:0] mem_q [FIFO_DEPTH];
    // extra msb tells full from empty
    logic [FIFO_ABITS:0]  wr_ptr_q;
    logic [FIFO_ABITS:0]  rd_ptr_q;
    logic                 empty;
    logic                 full;
    logic                 push;
    logic                 pop;

    assign empty = (wr_ptr_q == rd_ptr_q);
    assign full  = (wr_ptr_q[FIFO_ABITS] != rd_ptr_q[FIFO_ABITS])
                   && (wr_ptr_q[FIFO_ABITS-1:0] == rd_ptr_q[FIFO_ABITS-1:0]);

    // words arriving while full are lost
    assign push = trig_word_i.valid && !full;
    assign pop  = trigout_tvalid_o && trigout_tready_i;

    always_ff @(posedge sysclk_i) begin
        if (runrst_i) begin
            wr_ptr_q   <= '0;
            rd_ptr_q   <= '0;
            overflow_o <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            // sticky until next run start
            if (trig_word_i.valid && full) begin
                overflow_o <= 1'b1;
            end
        end
    end

    always_ff @(posedge sysclk_i) begin
        if (push) begin
            mem_q[wr_ptr_q[FIFO_ABITS-1:0]] <= trig_word_i.data;
        end
    end

    // head of queue read straight out, so data holds until popped
    assign trigout_tvalid_o = !empty;
    assign trigout_tdata_o  = mem_q[rd_ptr_q[FIFO_ABITS-1:0]];

endmodule

`default_nettype wire

// File: design/trig_pkg.sv
`default_nettype none

package trig_pkg;

    // channel count and event address geometry
    localparam int N_CHAN        = 8;
    localparam int ADDR_BITS     = 12;
    localparam int WORD_BITS     = 16;
    // one trigger memory entry per event address
    localparam int MEM_DEPTH     = 1 << ADDR_BITS;

    // channel word layout: flag on top, address above the two spare lsbs
    localparam int TRIG_FLAG_BIT = 15;
    localparam int ADDR_LSB      = 2;

    // width of the latency and holdoff settings
    localparam int CNT_BITS      = 16;

    // output fifo
    localparam int FIFO_DEPTH    = 16;
    localparam int FIFO_ABITS    = $clog2(FIFO_DEPTH);

    typedef enum logic [1:0] {
        RUN_IDLE,
        RUN_LATENCY,
        RUN_READOUT
    } run_state_e;

    // 0 is AND, 1 is OR
    typedef enum logic {
        L2_AND = 1'b0,
        L2_OR  = 1'b1
    } l2_logic_e;

    // configuration captured at run start
    typedef struct packed {
        logic [CNT_BITS-1:0]  latency;
        logic [ADDR_BITS-1:0] offset;
        logic [CNT_BITS-1:0]  holdoff;
        logic                 rf_en;
        l2_logic_e            l2_logic;
    } trig_cfg_t;

    typedef struct packed {
        logic                 valid;
        logic [ADDR_BITS-1:0] addr;
    } rd_req_t;

    typedef struct packed {
        logic                 valid;
        logic [ADDR_BITS-1:0] addr;
        logic [N_CHAN-1:0]    bits;
    } scan_t;

    typedef struct packed {
        logic                 valid;
        logic [WORD_BITS-1:0] data;
    } trig_word_t;

endpackage

`default_nettype wire

// File: design/trig_process_top.sv
`timescale 1ns/1ps
`default_nettype none

module trig_process_top import trig_pkg::*; (
    input  wire                        sysclk_i,
    input  wire                        runrst_i,
    input  wire                        runstop_i,
    // run configuration, captured at run start
    input  wire [CNT_BITS-1:0]         trig_latency_i,
    input  wire [ADDR_BITS-1:0]        trig_offset_i,
    input  wire [CNT_BITS-1:0]         trig_holdoff_i,
    input  wire                        rf_en_i,
    input  wire l2_logic_e             l2_logic_i,
    // mask loads at any time
    input  wire [N_CHAN-1:0]           trigmask_i,
    input  wire                        trigmask_update_i,
    // channel words, channel 0 in the low word
    input  wire [N_CHAN*WORD_BITS-1:0] trigin_dat_i,
    input  wire                        trigin_valid_i,
    output wire                        running_o,
    output wire [ADDR_BITS-1:0]        address_o,
    // trigger word stream
    output wire [WORD_BITS-1:0]        trigout_tdata_o,
    output wire                        trigout_tvalid_o,
    input  wire                        trigout_tready_i,
    output wire                        overflow_o
);

    trig_cfg_t  cfg;
    rd_req_t    rd_req;
    scan_t      scan;
    trig_word_t trig_word;

    // run state, event address, readout pointer
    trig_run_ctrl u_run (
        .sysclk_i       (sysclk_i),
        .runrst_i       (runrst_i),
        .runstop_i      (runstop_i),
        .trig_latency_i (trig_latency_i),
        .trig_offset_i  (trig_offset_i),
        .trig_holdoff_i (trig_holdoff_i),
        .rf_en_i        (rf_en_i),
        .l2_logic_i     (l2_logic_i),
        .cfg_o          (cfg),
        .rd_req_o       (rd_req),
        .running_o      (running_o),
        .address_o      (address_o)
    );

    // per-channel trigger bits by address
    trig_store u_store (
        .sysclk_i       (sysclk_i),
        .runrst_i       (runrst_i),
        .running_i      (running_o),
        .trigin_dat_i   (trigin_dat_i),
        .trigin_valid_i (trigin_valid_i),
        .rd_req_i       (rd_req),
        .scan_o         (scan)
    );

    // mask, and/or, holdoff
    trig_leveltwo u_l2 (
        .sysclk_i          (sysclk_i),
        .runrst_i          (runrst_i),
        .running_i         (running_o),
        .cfg_i             (cfg),
        .trigmask_i        (trigmask_i),
        .trigmask_update_i (trigmask_update_i),
        .scan_i            (scan),
        .trig_word_o       (trig_word)
    );

    trig_out_fifo u_fifo (
        .sysclk_i         (sysclk_i),
        .runrst_i         (runrst_i),
        .trig_word_i      (trig_word),
        .trigout_tready_i (trigout_tready_i),
        .trigout_tdata_o  (trigout_tdata_o),
        .trigout_tvalid_o (trigout_tvalid_o),
        .overflow_o       (overflow_o)
    );

endmodule

`default_nettype wire

// File: design/trig_run_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module trig_run_ctrl import trig_pkg::*; (
    input  wire                   sysclk_i,
    input  wire                   runrst_i,
    input  wire                   runstop_i,
    input  wire [CNT_BITS-1:0]    trig_latency_i,
    input  wire [ADDR_BITS-1:0]   trig_offset_i,
    input  wire [CNT_BITS-1:0]    trig_holdoff_i,
    input  wire                   rf_en_i,
    input  wire l2_logic_e        l2_logic_i,
    output trig_cfg_t             cfg_o,
    output rd_req_t               rd_req_o,
    output logic                  running_o,
    output logic [ADDR_BITS-1:0]  address_o
);

    run_state_e           state_q;
    logic [CNT_BITS-1:0]  lat_cnt_q;
    logic [ADDR_BITS-1:0] rd_ptr_q;
    logic                 lat_done;

    // settings only move at run start
    always_ff @(posedge sysclk_i) begin
        if (runrst_i) begin
            cfg_o.latency  <= trig_latency_i;
            cfg_o.offset   <= trig_offset_i;
            cfg_o.holdoff  <= trig_holdoff_i;
            cfg_o.rf_en    <= rf_en_i;
            cfg_o.l2_logic <= l2_logic_i;
        end
    end

    // lat_cnt_q equals cycles since run start, so readout begins on cycle "latency"
    assign lat_done = ({1'b0, lat_cnt_q} + 17'd1) >= {1'b0, cfg_o.latency};

    always_ff @(posedge sysclk_i) begin
        if (runrst_i) begin
            state_q   <= RUN_LATENCY;
            running_o <= 1'b1;
        end else if (runstop_i) begin
            state_q   <= RUN_IDLE;
            running_o <= 1'b0;
        end else begin
            case (state_q)
                RUN_LATENCY: begin
                    if (lat_done) begin
                        state_q <= RUN_READOUT;
                    end
                end
                // readout runs until the stop
                RUN_READOUT: state_q <= RUN_READOUT;
                default:     state_q <= RUN_IDLE;
            endcase
        end
    end

    // latency counter only runs while waiting
    always_ff @(posedge sysclk_i) begin
        if (runrst_i) begin
            lat_cnt_q <= '0;
        end else if (state_q == RUN_LATENCY) begin
            lat_cnt_q <= lat_cnt_q + 1'b1;
        end
    end

    // event address is 1 on the first running cycle, wraps naturally
    always_ff @(posedge sysclk_i) begin
        if (runrst_i) begin
            address_o <= {{(ADDR_BITS-1){1'b0}}, 1'b1};
        end else if (running_o) begin
            address_o <= address_o + 1'b1;
        end
    end

    // readout pointer trails the event address by the latency
    always_ff @(posedge sysclk_i) begin
        if (runrst_i) begin
            rd_ptr_q <= {{(ADDR_BITS-1){1'b0}}, 1'b1};
        end else if (state_q == RUN_READOUT) begin
            rd_ptr_q <= rd_ptr_q + 1'b1;
        end
    end

    assign rd_req_o.valid = (state_q == RUN_READOUT);
    assign rd_req_o.addr  = rd_ptr_q;

endmodule

`default_nettype wire

// File: design/trig_store.sv
`timescale 1ns/1ps
`default_nettype none

module trig_store import trig_pkg::*; (
    input  wire                        sysclk_i,
    input  wire                        runrst_i,
    input  wire                        running_i,
    input  wire [N_CHAN*WORD_BITS-1:0] trigin_dat_i,
    input  wire                        trigin_valid_i,
    input  wire rd_req_t               rd_req_i,
    output scan_t                      scan_o
);

    // one read bit per channel, gathered into the scan word
    logic [N_CHAN-1:0]    rd_bits;
    logic                 scan_valid_q;
    logic [ADDR_BITS-1:0] scan_addr_q;

    for (genvar ch = 0; ch < N_CHAN; ch++) begin : g_chan
        logic [WORD_BITS-1:0] word;
        logic                 wr_en;
        logic [ADDR_BITS-1:0] wr_addr;
        // one bit per event address
        logic [MEM_DEPTH-1:0] mem_q;

        // channel 0 sits in the low word
        assign word    = trigin_dat_i[ch*WORD_BITS +: WORD_BITS];
        assign wr_en   = running_i && trigin_valid_i && word[TRIG_FLAG_BIT];
        // the two lsbs of the word carry no address
        assign wr_addr = word[ADDR_LSB +: ADDR_BITS];

        always_ff @(posedge sysclk_i) begin
            if (runrst_i) begin
                // a new run starts with no leftover triggers
                mem_q <= '0;
            end else begin
                // read clears the entry
                if (rd_req_i.valid) begin
                    mem_q[rd_req_i.addr] <= 1'b0;
                end
                // a fresh trigger on the same entry wins over the clear
                if (wr_en) begin
                    mem_q[wr_addr] <= 1'b1;
                end
            end
        end

        // registered read, old contents come out
        always_ff @(posedge sysclk_i) begin
            if (rd_req_i.valid) begin
                rd_bits[ch] <= mem_q[rd_req_i.addr];
            end
        end
    end

    // address and valid follow the request by one cycle
    always_ff @(posedge sysclk_i) begin
        if (runrst_i) begin
            scan_valid_q <= 1'b0;
        end else begin
            scan_valid_q <= rd_req_i.valid;
        end
        scan_addr_q <= rd_req_i.addr;
    end

    assign scan_o = {scan_valid_q, scan_addr_q, rd_bits};

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# build and run with verilator, fail if the log reports failure
verilator --binary --timing --assert -f sim.f --top-module tb_trig_process -o simv \
    > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/simv > sim.log 2>&1 ; cat sim.log
grep -q "Test failed" sim.log && exit 1 || grep -q "Test passed" sim.log || exit 1
exit 0

// File: sim.f
design/trig_pkg.sv
design/trig_run_ctrl.sv
design/trig_store.sv
design/trig_leveltwo.sv
design/trig_out_fifo.sv
design/trig_process_top.sv
test/trig_process_chk.sv
test/tb_trig_process.sv

// File: test/tb_trig_process.sv
`timescale 1ns/1ps
`default_nettype none

module tb_trig_process import trig_pkg::*;;

    logic                        sysclk_i;
    logic                        runrst_i;
    logic                        runstop_i;
    logic [CNT_BITS-1:0]         trig_latency_i;
    logic [ADDR_BITS-1:0]        trig_offset_i;
    logic [CNT_BITS-1:0]         trig_holdoff_i;
    logic                        rf_en_i;
    l2_logic_e                   l2_logic_i;
    logic [N_CHAN-1:0]           trigmask_i;
    logic                        trigmask_update_i;
    logic [N_CHAN*WORD_BITS-1:0] trigin_dat_i;
    logic                        trigin_valid_i;
    logic                        trigout_tready_i;
    wire                         running_o;
    wire  [ADDR_BITS-1:0]        address_o;
    wire  [WORD_BITS-1:0]        trigout_tdata_o;
    wire                         trigout_tvalid_o;
    wire                         overflow_o;

    integer               seed;
    int                   val_err;
    int                   misc_err;
    logic                 stall;
    // latency and offset of the run in progress
    int                   cur_lat;
    int                   cur_off;
    // stream valid at the previous negedge
    logic                 tvalid_d;
    // planned channel bits per event address
    logic [N_CHAN-1:0]    trig_map [MEM_DEPTH];
    logic [WORD_BITS-1:0] exp_q [$];

    trig_process_top dut0 (.*);

    initial begin
        sysclk_i = 1'b0;
        forever #4 sysclk_i = ~sysclk_i;
    end

    // ready low on about one cycle in eight, or held low for a stall
    always @(posedge sysclk_i) begin
        trigout_tready_i <= stall ? 1'b0 : (($random(seed) & 7) != 0);
    end

    // a transfer on the next rising edge is already visible at the negedge before it
    always @(negedge sysclk_i) begin
        logic [WORD_BITS-1:0] e;
        logic [ADDR_BITS-1:0] first_at;
        // a word landing in the empty fifo shows latency plus 3 after its scan address
        if (!runrst_i && trigout_tvalid_o && tvalid_d === 1'b0) begin
            first_at = trigout_tdata_o[ADDR_LSB +: ADDR_BITS] + cur_off[ADDR_BITS-1:0]
                       + cur_lat[ADDR_BITS-1:0] + 12'd3;
            if (address_o !== first_at) begin
                $display("** Error at %0t: address_o got %0d expected %0d",
                         $time, address_o, first_at);
                val_err++;
            end
        end
        if (!runrst_i && trigout_tvalid_o && trigout_tready_i) begin
            if (exp_q.size() == 0) begin
                $display("unexpected output word %h at %0t", trigout_tdata_o, $time);
                misc_err++;
            end else begin
                e = exp_q.pop_front();
                if (trigout_tdata_o !== e) begin
                    $display("** Error at %0t: trigout_tdata_o got %h expected %h",
                             $time, trigout_tdata_o, e);
                    val_err++;
                end
            end
        end
        tvalid_d = trigout_tvalid_o;
    end

    // expected words for scanned addresses 1 to hi
    function automatic void predict(input l2_logic_e lg, input logic [N_CHAN-1:0] ma,
                                    input logic [N_CHAN-1:0] mb, input int sw, input logic rf,
                                    input int hold, input logic [ADDR_BITS-1:0] off,
                                    input int hi);
        int                   hcnt;
        logic [N_CHAN-1:0]    en;
        logic [N_CHAN-1:0]    h;
        logic                 fire;
        logic [ADDR_BITS-1:0] aa;
        hcnt = 0;
        for (int a = 1; a <= hi; a++) begin
            en = (a < sw) ? ~ma : ~mb;
            h = trig_map[a] & en;
            fire = (lg == L2_OR) ? (h != '0) : ((en != '0) && (h == en));
            aa = a[ADDR_BITS-1:0];
            if (hcnt > 0) begin
                hcnt--;
            end else if (fire && rf) begin
                exp_q.push_back({2'b10, aa - off, 2'b00});
                hcnt = hold;
            end
        end
    endfunction

    task automatic clear_map();
        for (int a = 0; a < MEM_DEPTH; a++) begin
            trig_map[a] = '0;
        end
    endtask

    // roughly one address in four gets random channel bits
    task automatic fill_random(input int lo, input int hi);
        logic [31:0] r;
        for (int a = lo; a <= hi; a++) begin
            r = $random(seed);
            if (r[31:30] == 2'b00) begin
                trig_map[a] = r[N_CHAN-1:0];
            end
        end
    endtask

    task automatic start_run(input int lat, input int off, input int hold,
                             input logic rf, input l2_logic_e lg, input logic [N_CHAN-1:0] m);
        @(posedge sysclk_i);
        cur_lat = lat;
        cur_off = off;
        trig_latency_i <= lat[CNT_BITS-1:0];
        trig_offset_i  <= off[ADDR_BITS-1:0];
        trig_holdoff_i <= hold[CNT_BITS-1:0];
        rf_en_i        <= rf;
        l2_logic_i     <= lg;
        runrst_i       <= 1'b1;
        repeat (8) @(posedge sysclk_i);
        runrst_i          <= 1'b0;
        trigmask_i        <= m;
        trigmask_update_i <= 1'b1;
        // first cycle out of reset
        @(negedge sysclk_i);
        if (running_o !== 1'b1) begin
            $display("** Error at %0t: running_o got %b expected 1", $time, running_o);
            val_err++;
        end
        if (address_o !== 12'd1) begin
            $display("** Error at %0t: address_o got %0d expected 1", $time, address_o);
            val_err++;
        end
        @(posedge sysclk_i);
        trigmask_update_i <= 1'b0;
    endtask

    task automatic wait_addr(input int target);
        int t;
        t = 0;
        while (address_o < target[ADDR_BITS-1:0] && t < 5000) begin
            @(posedge sysclk_i);
            t++;
        end
        if (t >= 5000) begin
            $display("timeout waiting for address %0d", target);
            misc_err++;
        end
    endtask

    // stamp channel words with the live address and optionally load a mask
    task automatic drive_range(input int lo, input int hi, input int upd_at,
                               input logic [N_CHAN-1:0] upd_mask);
        int                          t;
        logic [ADDR_BITS-1:0]        a;
        logic [N_CHAN*WORD_BITS-1:0] dat;
        t = 0;
        while (address_o <= hi[ADDR_BITS-1:0] && t < 5000) begin
            @(posedge sysclk_i);
            a = address_o;
            dat = '0;
            for (int ch = 0; ch < N_CHAN; ch++) begin
                if (a >= lo[ADDR_BITS-1:0] && trig_map[a][ch]) begin
                    dat[ch*WORD_BITS +: WORD_BITS] = {2'b10, a, 2'b00};
                end
            end
            trigin_dat_i      <= dat;
            trigin_valid_i    <= (dat != '0);
            trigmask_i        <= upd_mask;
            trigmask_update_i <= (int'(a) == upd_at);
            t++;
        end
        @(posedge sysclk_i);
        trigin_valid_i    <= 1'b0;
        trigmask_update_i <= 1'b0;
        if (t >= 5000) begin
            $display("timeout driving addresses up to %0d", hi);
            misc_err++;
        end
    endtask

    // let readout pass hi, stop the run and drain the stream
    task automatic end_run(input int hi, input int lat);
        int t;
        wait_addr(hi + lat + 6);
        @(posedge sysclk_i);
        runstop_i <= 1'b1;
        @(posedge sysclk_i);
        runstop_i <= 1'b0;
        @(negedge sysclk_i);
        if (running_o !== 1'b0) begin
            $display("running_o still high after runstop_i");
            misc_err++;
        end
        t = 0;
        while ((exp_q.size() != 0 || trigout_tvalid_o) && t < 3000) begin
            @(posedge sysclk_i);
            t++;
        end
        if (t >= 3000) begin
            $display("timeout draining, %0d words never arrived", exp_q.size());
            misc_err++;
            exp_q.delete();
        end
    endtask

    initial begin
        seed = 77863;
        val_err = 0;
        misc_err = 0;
        stall <= 1'b0;
        runrst_i <= 1'b1;
        runstop_i <= 1'b0;
        trig_latency_i <= '0;
        trig_offset_i <= '0;
        trig_holdoff_i <= '0;
        rf_en_i <= 1'b0;
        l2_logic_i <= L2_OR;
        trigmask_i <= '1;
        trigmask_update_i <= 1'b0;
        trigin_dat_i <= '0;
        trigin_valid_i <= 1'b0;
        trigout_tready_i <= 1'b0;
        // or mode with random triggers
        clear_map();
        fill_random(10, 300);
        predict(L2_OR, 8'h00, 8'h00, 0, 1'b1, 0, 12'd5, 300);
        start_run(20, 5, 0, 1'b1, L2_OR, 8'h00);
        drive_range(10, 300, 0, 8'h00);
        end_run(300, 20);
        // and mode with channels 1 to 3 enabled
        clear_map();
        fill_random(10, 400);
        predict(L2_AND, 8'hf1, 8'hf1, 0, 1'b1, 0, 12'd0, 400);
        start_run(20, 0, 0, 1'b1, L2_AND, 8'hf1);
        drive_range(10, 400, 0, 8'hf1);
        end_run(400, 20);
        // clusters reach past the end of the holdoff window
        clear_map();
        for (int c = 20; c < 300; c += 40) begin
            fill_random(c, c + 15);
            trig_map[c] = 8'h01;
        end
        predict(L2_OR, 8'h00, 8'h00, 0, 1'b1, 10, 12'd3, 300);
        start_run(20, 3, 10, 1'b1, L2_OR, 8'h00);
        drive_range(10, 300, 0, 8'h00);
        end_run(300, 20);
        // mask swap while the scan is near address 150
        clear_map();
        fill_random(10, 120);
        fill_random(180, 300);
        predict(L2_OR, 8'hf0, 8'h0f, 150, 1'b1, 0, 12'd0, 300);
        start_run(20, 0, 0, 1'b1, L2_OR, 8'hf0);
        drive_range(10, 300, 171, 8'h0f);
        end_run(300, 20);
        // nothing comes out with rf disabled
        clear_map();
        fill_random(10, 200);
        start_run(20, 0, 0, 1'b0, L2_OR, 8'h00);
        drive_range(10, 200, 0, 8'h00);
        end_run(200, 20);
        // triggers after the stop are ignored
        clear_map();
        start_run(20, 0, 0, 1'b1, L2_OR, 8'h00);
        end_run(0, 20);
        repeat (40) begin
            @(posedge sysclk_i);
            trigin_dat_i   <= {N_CHAN{16'h8000 | {2'b00, 12'd40, 2'b00}}};
            trigin_valid_i <= 1'b1;
        end
        trigin_valid_i <= 1'b0;
        repeat (80) @(posedge sysclk_i);
        // long stall with twelve dense triggers
        clear_map();
        for (int a = 40; a < 52; a++) begin
            trig_map[a] = 8'h01;
        end
        predict(L2_OR, 8'h00, 8'h00, 0, 1'b1, 0, 12'd0, 100);
        start_run(20, 0, 0, 1'b1, L2_OR, 8'h00);
        stall <= 1'b1;
        drive_range(10, 60, 0, 8'h00);
        wait_addr(120);
        stall <= 1'b0;
        end_run(100, 20);
        if (overflow_o !== 1'b0) begin
            $display("overflow_o set with fewer than 16 words pending");
            misc_err++;
        end
        $display("errors: value %0d, other %0d", val_err, misc_err);
        if (val_err == 0 && misc_err == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: test/trig_process_chk.sv
`timescale 1ns/1ps
`default_nettype none

module trig_process_chk import trig_pkg::*; (
    input wire                 sysclk_i,
    input wire                 runrst_i,
    input wire [WORD_BITS-1:0] trigout_tdata_o,
    input wire                 trigout_tvalid_o,
    input wire                 trigout_tready_i,
    input wire                 overflow_o
);

    // a stalled word keeps valid and data
    hold_under_stall: assert property (@(posedge sysclk_i) disable iff (runrst_i)
        (trigout_tvalid_o && !trigout_tready_i) |=> (trigout_tvalid_o && $stable(trigout_tdata_o)))
        else $error("stream word changed while stalled");

    // reset empties the fifo and clears overflow
    empty_after_reset: assert property (@(posedge sysclk_i)
        runrst_i |=> (!trigout_tvalid_o && !overflow_o))
        else $error("stream valid or overflow high after reset");

endmodule

bind trig_out_fifo trig_process_chk chk0 (.*);

`default_nettype wire
